//--- verilog/tconv_cfg_pkg.sv
package tconv_cfg_pkg;

    // ==================================================
    // Data widths
    // ==================================================
    // Signed sample and tap width
    parameter int DW = 16;
    // Signed accumulator width, full product fits
    parameter int ACC_W = 32;

    // ==================================================
    // Address widths and depths
    // ==================================================
    // Input line, 16 samples
    parameter int IF_ADDR_W = 4;
    parameter int LINE_WORDS = 2 ** IF_ADDR_W;
    // Accumulator RAM, 64 output words
    parameter int OUT_ADDR_W = 6;
    parameter int OUT_WORDS = 2 ** OUT_ADDR_W;

    // ==================================================
    // Command field limits
    // ==================================================
    // Tap index on the write port
    parameter int TAP_W = 2;
    // Leading output positions dropped
    parameter int CROP_W = 2;
    // Upsampling step, 1 or 2
    parameter int MAX_STRIDE = 2;
    parameter int STRIDE_W = $clog2(MAX_STRIDE + 1);

endpackage

//--- verilog/tconv_types_pkg.sv
package tconv_types_pkg;

    // ==================================================
    // Job command
    // ==================================================
    // Latched by the producer on start
    typedef struct packed {
        logic [tconv_cfg_pkg::IF_ADDR_W:0]    count;
        logic [tconv_cfg_pkg::STRIDE_W-1:0]   stride;
        logic [tconv_cfg_pkg::CROP_W-1:0]     crop;
        logic [tconv_cfg_pkg::OUT_ADDR_W:0]   out_len;
    } job_cmd_t;

    // ==================================================
    // Tagged partial product
    // ==================================================
    // keep low means the mapped address fell outside the output
    typedef struct packed {
        logic signed [tconv_cfg_pkg::ACC_W-1:0] value;
        logic [tconv_cfg_pkg::OUT_ADDR_W-1:0]   out_addr;
        logic                                   keep;
    } partial_t;

    // ==================================================
    // Write ports
    // ==================================================
    // Single-cycle strobes, idle only
    typedef struct packed {
        logic                                we;
        logic [tconv_cfg_pkg::TAP_W-1:0]     tap;
        logic signed [tconv_cfg_pkg::DW-1:0] data;
    } tap_wr_t;

    typedef struct packed {
        logic                                 we;
        logic [tconv_cfg_pkg::IF_ADDR_W-1:0]  addr;
        logic signed [tconv_cfg_pkg::DW-1:0]  data;
    } line_wr_t;

endpackage

//--- verilog/partial_producer.sv
`timescale 1ns/1ns

module partial_producer #(
    parameter int DIM = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  tconv_types_pkg::tap_wr_t       tap_wr,
    input  tconv_types_pkg::line_wr_t      line_wr,
    input  logic                           start,
    input  tconv_types_pkg::job_cmd_t      cmd,
    input  logic                           full,
    output logic                           push,
    output tconv_types_pkg::partial_t      data,
    output logic                           busy
);

    localparam int C_W = (DIM > 1) ? $clog2(DIM) : 1;

    // Tap registers and input line memory
    logic signed [tconv_cfg_pkg::DW-1:0] taps [DIM];
    logic signed [tconv_cfg_pkg::DW-1:0] line_mem [tconv_cfg_pkg::LINE_WORDS];

    // Loop state
    tconv_types_pkg::job_cmd_t            cmd_q;
    logic                                 run;
    logic [tconv_cfg_pkg::IF_ADDR_W-1:0]  i_cnt;
    logic [C_W-1:0]                       c_cnt;
    logic [tconv_cfg_pkg::IF_ADDR_W:0]    cur_count;
    logic                                 start_ok;
    logic                                 issue;

    // Stage 1, operands read
    logic                                 s1_valid;
    logic signed [tconv_cfg_pkg::DW-1:0]  s1_x;
    logic signed [tconv_cfg_pkg::DW-1:0]  s1_w;
    logic [tconv_cfg_pkg::IF_ADDR_W-1:0]  s1_i;
    logic [C_W-1:0]                       s1_c;

    // Stage 2, product and mapped address
    logic                                 s2_valid;
    tconv_types_pkg::partial_t            s2_data;
    tconv_types_pkg::partial_t            s2_next;

    // ==================================================
    // Storage writes
    // ==================================================
    always_ff @(posedge clk) begin
        // Out-of-range tap index dropped
        if (tap_wr.we && (int'(tap_wr.tap) < DIM))
            taps[tap_wr.tap[C_W-1:0]] <= tap_wr.data;
        if (line_wr.we)
            line_mem[line_wr.addr] <= line_wr.data;
    end

    // ==================================================
    // Sample and tap loop
    // ==================================================
    // Zero-length jobs never start
    assign start_ok  = start && !busy && (cmd.count != '0);
    // First issue happens in the start cycle itself
    assign cur_count = run ? cmd_q.count : cmd.count;
    assign issue     = (run || start_ok) && !full;

    always_ff @(posedge clk) begin
        if (reset) begin
            run   <= 1'b0;
            i_cnt <= '0;
            c_cnt <= '0;
        end else if (issue) begin
            if (c_cnt == C_W'(DIM - 1)) begin
                c_cnt <= '0;
                if ({1'b0, i_cnt} == cur_count - 1'b1) begin
                    // Last sample, back to idle
                    i_cnt <= '0;
                    run   <= 1'b0;
                end else begin
                    i_cnt <= i_cnt + 1'b1;
                    run   <= 1'b1;
                end
            end else begin
                c_cnt <= c_cnt + 1'b1;
                run   <= 1'b1;
            end
        end else if (start_ok) begin
            // Start under full, loop waits at position zero
            run <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok)
            cmd_q <= cmd;
    end

    // ==================================================
    // Two-stage pipeline
    // ==================================================
    always_comb begin
        int pos;
        // Raw output position minus crop
        pos = int'(s1_i) * int'(cmd_q.stride) + int'(s1_c) - int'(cmd_q.crop);
        s2_next.value    = tconv_cfg_pkg::ACC_W'(s1_x * s1_w);
        s2_next.out_addr = tconv_cfg_pkg::OUT_ADDR_W'(pos);
        s2_next.keep     = (pos >= 0) && (pos < int'(cmd_q.out_len));
    end

    // Valid bits, frozen while full
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (!full) begin
            s1_valid <= issue;
            s2_valid <= s1_valid;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (!full) begin
            s1_x    <= line_mem[i_cnt];
            s1_w    <= taps[c_cnt];
            s1_i    <= i_cnt;
            s1_c    <= c_cnt;
            s2_data <= s2_next;
        end
    end

    assign push = s2_valid && !full;
    assign data = s2_data;
    assign busy = run || s1_valid || s2_valid;

    // ==================================================
    // Checks
    // ==================================================
    // Held partial survives back-pressure unchanged
    a_hold_on_full: assert property (@(posedge clk) disable iff (reset)
        s2_valid && full |=> s2_valid && $stable(data));

endmodule

//--- verilog/partial_fifo.sv
`timescale 1ns/1ns

module partial_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  tconv_types_pkg::partial_t  push_data,
    input  logic                       pop,
    output tconv_types_pkg::partial_t  head,
    output logic                       full,
    output logic                       empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    tconv_types_pkg::partial_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [PTR_W:0]            count;
    logic                      do_push;
    logic                      do_pop;

    // Illegal requests have no effect
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // ==================================================
    // Pointers and occupancy
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // Simultaneous push and pop leaves count alone
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    // Head shows in the cycle after the push
    assign head  = mem[rd_ptr];
    assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    // ==================================================
    // Checks
    // ==================================================
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty);

endmodule

//--- verilog/overlap_accumulator.sv
`timescale 1ns/1ns

module overlap_accumulator (
    input  logic                                     clk,
    input  logic                                     reset,
    input  tconv_types_pkg::partial_t                head,
    input  logic                                     empty,
    output logic                                     pop,
    input  logic                                     clear,
    input  logic [tconv_cfg_pkg::OUT_ADDR_W-1:0]     rd_addr,
    output logic signed [tconv_cfg_pkg::ACC_W-1:0]   rd_data,
    output logic                                     write_pending,
    output logic                                     busy
);

    // Accumulator RAM
    logic signed [tconv_cfg_pkg::ACC_W-1:0] acc_mem [tconv_cfg_pkg::OUT_WORDS];

    // Write in flight
    logic                                    pend_valid;
    logic [tconv_cfg_pkg::OUT_ADDR_W-1:0]    pend_addr;
    logic signed [tconv_cfg_pkg::ACC_W-1:0]  pend_value;
    logic signed [tconv_cfg_pkg::ACC_W-1:0]  old_q;

    // Clear sweep
    logic [tconv_cfg_pkg::OUT_ADDR_W-1:0]    sweep_addr;

    // Read-after-write hazard
    logic                                    stall;

    // ==================================================
    // Pop control
    // ==================================================
    // Same word as the pending write, wait one cycle
    // Discarded entries never touch the RAM, no stall needed
    assign stall = pend_valid && head.keep && (head.out_addr == pend_addr);

    // Sweep and its start cycle both block pops
    assign pop = !empty && !stall && !busy && !clear;

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
            busy       <= 1'b0;
            sweep_addr <= '0;
        end else begin
            pend_valid <= pop && head.keep;
            if (clear) begin
                busy       <= 1'b1;
                sweep_addr <= '0;
            end else if (busy) begin
                // Last word zeroed, sweep done
                if (sweep_addr == tconv_cfg_pkg::OUT_ADDR_W'(tconv_cfg_pkg::OUT_WORDS - 1))
                    busy <= 1'b0;
                sweep_addr <= sweep_addr + 1'b1;
            end
        end
    end

    // ==================================================
    // Read-modify-write
    // ==================================================
    // Old sum read at pop
    always_ff @(posedge clk) begin
        if (pop) begin
            old_q      <= acc_mem[head.out_addr];
            pend_value <= head.value;
            pend_addr  <= head.out_addr;
        end
    end

    // Single write port, sweep first
    always_ff @(posedge clk) begin
        if (busy)
            acc_mem[sweep_addr] <= '0;
        else if (pend_valid)
            acc_mem[pend_addr] <= old_q + pend_value;
    end

    // ==================================================
    // External read
    // ==================================================
    // One-cycle latency
    always_ff @(posedge clk) begin
        rd_data <= acc_mem[rd_addr];
    end

    assign write_pending = pend_valid;

    // ==================================================
    // Checks
    // ==================================================
    // Write from a pop before the clear never lands inside the sweep
    a_sweep_exclusive: assert property (@(posedge clk) disable iff (reset)
        busy |-> !write_pending);

endmodule

//--- verilog/tconv_top.sv
`timescale 1ns/1ns

module tconv_top #(
    parameter int DIM        = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  tconv_types_pkg::tap_wr_t                 tap_wr,
    input  tconv_types_pkg::line_wr_t                line_wr,
    input  logic                                     start,
    input  tconv_types_pkg::job_cmd_t                cmd,
    input  logic                                     clear,
    input  logic [tconv_cfg_pkg::OUT_ADDR_W-1:0]     rd_addr,
    output logic signed [tconv_cfg_pkg::ACC_W-1:0]   rd_data,
    output logic                                     job_done,
    output logic                                     acc_busy
);

    // Producer to FIFO
    logic                       push;
    tconv_types_pkg::partial_t  push_data;
    logic                       full;
    logic                       prod_busy;

    // FIFO to accumulator
    tconv_types_pkg::partial_t  head;
    logic                       empty;
    logic                       pop;
    logic                       write_pending;

    // Set by start, cleared by job_done
    logic                       job_active;

    // ==================================================
    // Producer
    // ==================================================
    partial_producer #(
        .DIM(DIM)
    ) u_producer (
        .clk(clk),
        .reset(reset),
        .tap_wr(tap_wr),
        .line_wr(line_wr),
        .start(start),
        .cmd(cmd),
        .full(full),
        .push(push),
        .data(push_data),
        .busy(prod_busy)
    );

    // ==================================================
    // Partial FIFO
    // ==================================================
    partial_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk(clk),
        .reset(reset),
        .push(push),
        .push_data(push_data),
        .pop(pop),
        .head(head),
        .full(full),
        .empty(empty)
    );

    // ==================================================
    // Accumulator
    // ==================================================
    overlap_accumulator u_accum (
        .clk(clk),
        .reset(reset),
        .head(head),
        .empty(empty),
        .pop(pop),
        .clear(clear),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .write_pending(write_pending),
        .busy(acc_busy)
    );

    // ==================================================
    // Job completion
    // ==================================================
    // Whole chain drained
    assign job_done = job_active && !prod_busy && empty && !write_pending;

    always_ff @(posedge clk) begin
        if (reset)
            job_active <= 1'b0;
        else if (start)
            job_active <= 1'b1;
        else if (job_done)
            job_active <= 1'b0;
    end

endmodule

//--- verif/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    // Free-running clock, 4 ns period
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- verif/tb_tconv_top.sv
`timescale 1ns/1ns

module tb_tconv_top;

    // Three taps with stride 2 put back-to-back partials on one word
    localparam int DIM        = 3;
    localparam int FIFO_DEPTH = 8;
    localparam int DW         = tconv_cfg_pkg::DW;
    localparam int ACC_W      = tconv_cfg_pkg::ACC_W;
    localparam int LINE_WORDS = tconv_cfg_pkg::LINE_WORDS;
    localparam int OUT_WORDS  = tconv_cfg_pkg::OUT_WORDS;
    localparam int OUT_ADDR_W = tconv_cfg_pkg::OUT_ADDR_W;
    localparam int CNT_W      = tconv_cfg_pkg::IF_ADDR_W + 1;
    localparam int LEN_W      = tconv_cfg_pkg::OUT_ADDR_W + 1;

    // ==================================================
    // Cycle bounds
    // ==================================================
    // Loading taps and the full line
    localparam int LOAD_BOUND  = DIM + LINE_WORDS + 4;
    // Longest job, with room for stalls
    localparam int JOB_BOUND   = LINE_WORDS * DIM * 2 + 40;
    // Two cycles per word read
    localparam int READ_BOUND  = 2 * OUT_WORDS + 4;
    localparam int CLEAR_BOUND = OUT_WORDS + 8;
    // Worst test runs two jobs, two reads and two clears
    localparam int TEST_BOUND  = 2 * (LOAD_BOUND + JOB_BOUND + READ_BOUND + CLEAR_BOUND);
    localparam int CYCLE_LIMIT = 10 + 5 * TEST_BOUND + 100;

    logic                               clk;
    logic                               reset;
    tconv_types_pkg::tap_wr_t           tap_wr;
    tconv_types_pkg::line_wr_t          line_wr;
    logic                               start;
    tconv_types_pkg::job_cmd_t          cmd;
    logic                               clear;
    logic [OUT_ADDR_W-1:0]              rd_addr;
    logic signed [ACC_W-1:0]            rd_data;
    logic                               job_done;
    logic                               acc_busy;

    // Stimulus values and reference model
    logic signed [DW-1:0]               tap_val [DIM];
    logic signed [DW-1:0]               line_val [LINE_WORDS];
    logic signed [ACC_W-1:0]            model_mem [OUT_WORDS];
    logic [31:0]                        lfsr_state = 32'h53f91ed4;
    int                                 errors = 0;
    int                                 checks = 0;
    int                                 cycle_count;

    clock_gen u_clock (
        .clk(clk),
        .reset(reset)
    );

    tconv_top #(
        .DIM(DIM),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uut (
        .clk(clk),
        .reset(reset),
        .tap_wr(tap_wr),
        .line_wr(line_wr),
        .start(start),
        .cmd(cmd),
        .clear(clear),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .job_done(job_done),
        .acc_busy(acc_busy)
    );

    // ==================================================
    // Random source
    // ==================================================
    // Right-shifting Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;
        return s >> 1;
    endfunction

    // One step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic randomize_data();
        logic [31:0] r;
        for (int c = 0; c < DIM; c++) begin
            take_bits(DW, r);
            tap_val[c] = r[DW-1:0];
        end
        for (int i = 0; i < LINE_WORDS; i++) begin
            take_bits(DW, r);
            line_val[i] = r[DW-1:0];
        end
    endtask

    // ==================================================
    // Reference model
    // ==================================================
    function automatic tconv_types_pkg::job_cmd_t make_cmd(input int count, input int stride,
                                                           input int crop, input int out_len);
        tconv_types_pkg::job_cmd_t c;
        c.count   = CNT_W'(count);
        c.stride  = tconv_cfg_pkg::STRIDE_W'(stride);
        c.crop    = tconv_cfg_pkg::CROP_W'(crop);
        c.out_len = LEN_W'(out_len);
        return c;
    endfunction

    task automatic model_clear();
        for (int a = 0; a < OUT_WORDS; a++)
            model_mem[a] = '0;
    endtask

    // Scatter x[i]*w[c] to i*stride + c - crop, inside 0..out_len-1 only
    task automatic model_add(input tconv_types_pkg::job_cmd_t c);
        int pos;
        logic signed [ACC_W-1:0] xe;
        logic signed [ACC_W-1:0] we;
        for (int i = 0; i < int'(c.count); i++) begin
            for (int t = 0; t < DIM; t++) begin
                pos = i * int'(c.stride) + t - int'(c.crop);
                xe  = line_val[i];
                we  = tap_val[t];
                if (pos >= 0 && pos < int'(c.out_len))
                    model_mem[pos] = model_mem[pos] + xe * we;
            end
        end
    endtask

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic check_sum(input string name, input logic signed [ACC_W-1:0] got,
                             input logic signed [ACC_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // ==================================================
    // Bus drivers
    // ==================================================
    task automatic write_taps();
        tconv_types_pkg::tap_wr_t wr;
        for (int c = 0; c < DIM; c++) begin
            wr.we   = 1'b1;
            wr.tap  = tconv_cfg_pkg::TAP_W'(c);
            wr.data = tap_val[c];
            @(posedge clk);
            tap_wr <= wr;
        end
        @(posedge clk);
        tap_wr <= '0;
    endtask

    task automatic write_line();
        tconv_types_pkg::line_wr_t wr;
        for (int i = 0; i < LINE_WORDS; i++) begin
            wr.we   = 1'b1;
            wr.addr = tconv_cfg_pkg::IF_ADDR_W'(i);
            wr.data = line_val[i];
            @(posedge clk);
            line_wr <= wr;
        end
        @(posedge clk);
        line_wr <= '0;
    endtask

    task automatic pulse_start(input tconv_types_pkg::job_cmd_t c);
        @(posedge clk);
        start <= 1'b1;
        cmd   <= c;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Waits for the done pulse, then checks that it lasts one cycle
    task automatic wait_job_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!job_done && waited < JOB_BOUND) begin
            @(negedge clk);
            waited++;
        end
        if (!job_done) begin
            errors++;
            $display("Error at %0t: job_done did not arrive within %0d cycles",
                     $time, JOB_BOUND);
        end else begin
            @(negedge clk);
            check_flag("job_done", job_done, 1'b0);
        end
    endtask

    task automatic clear_acc();
        int waited;
        @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        @(negedge clk);
        check_flag("acc_busy", acc_busy, 1'b1);
        waited = 0;
        while (acc_busy && waited < CLEAR_BOUND) begin
            @(negedge clk);
            waited++;
        end
        if (acc_busy) begin
            errors++;
            $display("Error at %0t: clear sweep still running after %0d cycles",
                     $time, CLEAR_BOUND);
        end
        model_clear();
    endtask

    // Read port has one cycle of latency
    task automatic check_all_words();
        for (int a = 0; a < OUT_WORDS; a++) begin
            @(posedge clk);
            rd_addr <= OUT_ADDR_W'(a);
            @(posedge clk);
            @(negedge clk);
            check_sum($sformatf("rd_data[%0d]", a), rd_data, model_mem[a]);
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    // Unit samples, so each word is a sum of taps
    task automatic overlap_sum_stride1();
        tconv_types_pkg::job_cmd_t c;
        c = make_cmd(6, 1, 0, OUT_WORDS);
        for (int t = 0; t < DIM; t++)
            tap_val[t] = DW'(t + 1);
        for (int i = 0; i < LINE_WORDS; i++)
            line_val[i] = 1;
        clear_acc();
        write_taps();
        write_line();
        model_add(c);
        pulse_start(c);
        wait_job_done();
        check_all_words();
    endtask

    // Last tap of one sample and first tap of the next share a word
    task automatic hazard_stride2_random();
        tconv_types_pkg::job_cmd_t c;
        c = make_cmd(LINE_WORDS, 2, 0, OUT_WORDS);
        randomize_data();
        clear_acc();
        write_taps();
        write_line();
        model_add(c);
        pulse_start(c);
        wait_job_done();
        check_all_words();
    endtask

    // Leading and trailing partials fall outside 0..9
    task automatic crop_discard();
        tconv_types_pkg::job_cmd_t c;
        c = make_cmd(8, 2, 3, 10);
        randomize_data();
        clear_acc();
        write_taps();
        write_line();
        model_add(c);
        pulse_start(c);
        wait_job_done();
        check_all_words();
    endtask

    task automatic two_jobs_accumulate();
        tconv_types_pkg::job_cmd_t c;
        clear_acc();
        c = make_cmd(8, 1, 0, OUT_WORDS);
        randomize_data();
        write_taps();
        write_line();
        model_add(c);
        pulse_start(c);
        wait_job_done();
        // Second job lands on top of the first, no clear between
        c = make_cmd(10, 2, 1, OUT_WORDS);
        randomize_data();
        write_taps();
        write_line();
        model_add(c);
        pulse_start(c);
        wait_job_done();
        check_all_words();
        clear_acc();
        check_all_words();
    endtask

    task automatic start_while_busy();
        tconv_types_pkg::job_cmd_t c;
        c = make_cmd(12, 1, 0, OUT_WORDS);
        randomize_data();
        clear_acc();
        write_taps();
        write_line();
        model_add(c);
        pulse_start(c);
        repeat (4) @(posedge clk);
        // Producer still busy, this one must be dropped
        pulse_start(make_cmd(LINE_WORDS, 2, 0, OUT_WORDS));
        wait_job_done();
        check_all_words();
    endtask

    // ==================================================
    // Watchdog
    // ==================================================
    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run exceeded %0d cycles, errors so far %0d", CYCLE_LIMIT, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        tap_wr  <= '0;
        line_wr <= '0;
        start   <= 1'b0;
        cmd     <= '0;
        clear   <= 1'b0;
        rd_addr <= '0;
        @(posedge clk);
        while (reset)
            @(posedge clk);
        overlap_sum_stride1();
        hazard_stride2_random();
        crop_discard();
        two_jobs_accumulate();
        start_while_busy();
        repeat (2) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- build.f
verilog/tconv_cfg_pkg.sv
verilog/tconv_types_pkg.sv
verilog/partial_producer.sv
verilog/partial_fifo.sv
verilog/overlap_accumulator.sv
verilog/tconv_top.sv
verif/clock_gen.sv
verif/tb_tconv_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_tconv_top -o sim_tconv

out=$(./obj_dir/sim_tconv)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi
